//--- Bender.yml
package:
  name: uart_bridge

sources:
  - uart_cfg_pkg.sv
  - uart_cmd_pkg.sv
  - cmd_decode.sv
  - uart_tx_frame.sv
  - uart_rx_frame.sv
  - read_result.sv
  - uart_bridge_top.sv
  - target: test
    files:
      - uart_device_model.sv
      - tb_uart_bridge.sv

//--- all.f
uart_cfg_pkg.sv
uart_cmd_pkg.sv
cmd_decode.sv
uart_tx_frame.sv
uart_rx_frame.sv
read_result.sv
uart_bridge_top.sv
uart_device_model.sv
tb_uart_bridge.sv

//--- cmd_decode.sv
`timescale 1ns/10ps

module cmd_decode (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::cmd_word_u cmd_in,
  input  logic                    cmd_vld,
  input  logic                    tx_rdy,
  input  logic                    tx_done,
  input  logic                    rd_close,
  output logic                    cmd_rdy,
  output logic                    tx_vld,
  output uart_cmd_pkg::tx_job_t   tx_job,
  output logic                    rd_open
);

  typedef enum logic [2:0] {
    s_idle,
    s_hdr,
    s_gap,
    s_data,
    s_read
  } state_e;

  state_e                             state;
  uart_cmd_pkg::cmd_word_u            cmd_q;
  uart_cmd_pkg::tx_job_t              job_q;
  logic                               job_pend;
  logic [uart_cfg_pkg::bit_cnt_w-1:0] bit_cnt;
  logic [uart_cfg_pkg::gap_cnt_w-1:0] gap_cnt;
  logic [7:0]                         hdr_byte;
  logic                               gap_end;

  function automatic uart_cmd_pkg::tx_job_t make_job(input logic [7:0] b);
    uart_cmd_pkg::tx_job_t j;
    j.data   = b;
    j.parity = ^b;  // Even parity
    j.stop   = 1'b1;
    return j;
  endfunction

  // Both views share the upper byte, so the header is the same for reads and writes
  assign hdr_byte = {cmd_in.wr.is_write, cmd_in.wr.addr};

  assign gap_end = (bit_cnt == uart_cfg_pkg::bit_last) && (gap_cnt == uart_cfg_pkg::gap_last);

  assign cmd_rdy = (state == s_idle);
  assign tx_vld  = job_pend;
  assign tx_job  = job_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= s_idle;
      job_pend <= 1'b0;
      rd_open  <= 1'b0;
      bit_cnt  <= '0;
      gap_cnt  <= '0;
    end
    else
    begin
      if (job_pend && tx_rdy)
        job_pend <= 1'b0;
      case (state)
        s_idle:
          if (cmd_vld)
          begin
            state    <= s_hdr;
            job_pend <= 1'b1;
          end
        s_hdr:
          if (tx_done)
          begin
            if (cmd_q.wr.is_write)
              state <= s_gap;
            else
            begin
              state   <= s_read;
              rd_open <= 1'b1;
            end
          end
        s_gap:
          if (gap_end)
          begin
            bit_cnt  <= '0;
            gap_cnt  <= '0;
            state    <= s_data;
            job_pend <= 1'b1;
          end
          else if (bit_cnt == uart_cfg_pkg::bit_last)
          begin
            bit_cnt <= '0;
            gap_cnt <= gap_cnt + 1'b1;
          end
          else
            bit_cnt <= bit_cnt + 1'b1;
        s_data:
          if (tx_done)
            state <= s_idle;
        s_read:
          if (rd_close)
          begin
            state   <= s_idle;
            rd_open <= 1'b0;
          end
        default:
          state <= s_idle;
      endcase
    end
  end

  // Header job is built at acceptance, the data job at the end of the gap
  always_ff @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
    begin
      cmd_q <= cmd_in;
      job_q <= make_job(hdr_byte);
    end
    else if (state == s_gap && gap_end)
      job_q <= make_job(cmd_q.wr.data);
  end

endmodule

//--- read_result.sv
`timescale 1ns/10ps

module read_result (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       rd_open,
  input  logic                       rx_vld,
  input  uart_cmd_pkg::rx_frame_t    rx_frame,
  output logic                       rd_close,
  output logic                       read_vld,
  output uart_cmd_pkg::read_result_t read_res
);

  logic [uart_cfg_pkg::timeout_cnt_w-1:0] to_cnt;
  logic                                   live;
  logic                                   timed_out;

  // The read stays live until the closing pulse has been seen by the sequencer
  assign live      = rd_open && !read_vld;
  assign timed_out = live && (to_cnt == uart_cfg_pkg::timeout_last);
  assign rd_close  = read_vld;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      to_cnt   <= '0;
      read_vld <= 1'b0;
    end
    else
    begin
      read_vld <= live && (rx_vld || timed_out);
      if (!rd_open)
        to_cnt <= '0;
      else if (live)
        to_cnt <= to_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (live && rx_vld)
    begin
      read_res.data <= rx_frame.data;
      if (!rx_frame.parity_ok)
        read_res.err <= uart_cmd_pkg::err_parity;
      else if (!rx_frame.stop_ok)
        read_res.err <= uart_cmd_pkg::err_stop;
      else
        read_res.err <= uart_cmd_pkg::err_none;
    end
    else if (timed_out)
    begin
      read_res.data <= 8'h00;
      read_res.err  <= uart_cmd_pkg::err_timeout;
    end
  end

endmodule

//--- tb_uart_bridge.sv
`timescale 1ns/10ps

module tb_uart_bridge;

  localparam int n_rows = 13;

  localparam logic [1:0] reply_normal   = 2'd0;
  localparam logic [1:0] reply_bad_par  = 2'd1;
  localparam logic [1:0] reply_bad_stop = 2'd2;
  localparam logic [1:0] reply_silent   = 2'd3;

  localparam longint wd_cycles = (longint'(n_rows) * 60 + 1000) * uart_cfg_pkg::bit_cycles;

  typedef struct packed {
    uart_cmd_pkg::cmd_word_u    cmd;
    logic [1:0]                 mode;
    logic [7:0]                 hdr;
    logic [7:0]                 wdata;
    uart_cmd_pkg::read_result_t res;
  } row_t;

  logic                       clk;
  logic                       rst_n;
  uart_cmd_pkg::cmd_word_u    cmd_in;
  logic                       cmd_vld;
  logic                       cmd_rdy;
  logic                       tx;
  logic                       rx;
  logic                       read_vld;
  uart_cmd_pkg::read_result_t read_res;
  logic [1:0]                 reply_mode;
  logic [3:0]                 reply_bits;
  logic                       frame_vld;
  logic [7:0]                 frame_byte;
  logic                       fmt_err;
  row_t                       tab [n_rows];
  logic [31:0]                rng;
  int                         frames_seen = 0;
  int                         reads_seen = 0;
  int                         exp_frames = 0;
  int                         exp_reads = 0;

  uart_bridge_top UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .rx       (rx),
    .cmd_rdy  (cmd_rdy),
    .tx       (tx),
    .read_vld (read_vld),
    .read_res (read_res)
  );

  uart_device_model u_device (
    .clk        (clk),
    .tx         (tx),
    .reply_mode (reply_mode),
    .reply_bits (reply_bits),
    .rx         (rx),
    .frame_vld  (frame_vld),
    .frame_byte (frame_byte),
    .fmt_err    (fmt_err)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic row_t make_row(input logic [15:0] cmd, input logic [1:0] mode,
                                    input logic [7:0] hdr, input logic [7:0] wdata,
                                    input logic [7:0] rdata, input uart_cmd_pkg::read_err_e err);
    row_t r;
    r.cmd      = cmd;
    r.mode     = mode;
    r.hdr      = hdr;
    r.wdata    = wdata;
    r.res.data = rdata;
    r.res.err  = err;
    return r;
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "Value mismatch");
    end
  endtask

  // Called at a falling edge, returns on the rising edge that accepts the command
  task automatic wait_accept();
    while (!(cmd_vld === 1'b1 && cmd_rdy === 1'b1))
      @(negedge clk);
    @(posedge clk);
  endtask

  task automatic wait_frame(output logic [7:0] b);
    @(negedge clk);
    while (frame_vld !== 1'b1)
      @(negedge clk);
    b = frame_byte;
  endtask

  task automatic wait_read();
    @(negedge clk);
    while (read_vld !== 1'b1)
      @(negedge clk);
  endtask

  // Model memory starts at addr ^ 8'h5A, writes update it
  task automatic fill_table();
    tab[0]  = make_row(16'h92A5, reply_normal, 8'h92, 8'hA5, 8'h00, uart_cmd_pkg::err_none);
    tab[1]  = make_row(16'h1200, reply_normal, 8'h12, 8'h00, 8'hA5, uart_cmd_pkg::err_none);
    tab[2]  = make_row(16'h3300, reply_normal, 8'h33, 8'h00, 8'h69, uart_cmd_pkg::err_none);
    tab[3]  = make_row(16'h0500, reply_bad_par, 8'h05, 8'h00, 8'h5F, uart_cmd_pkg::err_parity);
    tab[4]  = make_row(16'h7F00, reply_bad_stop, 8'h7F, 8'h00, 8'h25, uart_cmd_pkg::err_stop);
    tab[5]  = make_row(16'h2000, reply_silent, 8'h20, 8'h00, 8'h00, uart_cmd_pkg::err_timeout);
    tab[6]  = make_row(16'h20C3, reply_normal, 8'h20, 8'h00, 8'h7A, uart_cmd_pkg::err_none);
    tab[7]  = make_row(16'hFF3C, reply_normal, 8'hFF, 8'h3C, 8'h00, uart_cmd_pkg::err_none);
    tab[8]  = make_row(16'h8500, reply_normal, 8'h85, 8'h00, 8'h00, uart_cmd_pkg::err_none);
    tab[9]  = make_row(16'h7F00, reply_normal, 8'h7F, 8'h00, 8'h3C, uart_cmd_pkg::err_none);
    tab[10] = make_row(16'h0511, reply_normal, 8'h05, 8'h00, 8'h00, uart_cmd_pkg::err_none);
    tab[11] = make_row(16'h92FF, reply_normal, 8'h92, 8'hFF, 8'h00, uart_cmd_pkg::err_none);
    tab[12] = make_row(16'h1200, reply_bad_par, 8'h12, 8'h00, 8'hFF, uart_cmd_pkg::err_parity);
  endtask

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk)
  begin
    if (frame_vld === 1'b1)
      frames_seen <= frames_seen + 1;
    if (read_vld === 1'b1)
      reads_seen <= reads_seen + 1;
  end

  initial
  begin
    #(wd_cycles * 4);
    $display("Watchdog expired before the command table completed");
    $display("Simulation failed");
    $fatal(1, "Timeout");
  end

  initial
  begin
    wait (fmt_err === 1'b1);
    $display("Simulation failed");
    $fatal(1, "Device model saw a malformed frame");
  end

  initial
  begin
    int         gap;
    logic [7:0] b;
    row_t       row;
    rst_n      = 1'b0;
    cmd_vld    = 1'b0;
    cmd_in     = '0;
    rng        = 32'heb74;
    fill_table();
    reply_mode = tab[0].mode;
    reply_bits = 4'd1;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_equal(tx, 1'b1, "tx after reset");
    check_equal(cmd_rdy, 1'b1, "cmd_rdy after reset");
    check_equal(read_vld, 1'b0, "read_vld after reset");
    @(posedge clk);
    cmd_in  <= tab[0].cmd;
    cmd_vld <= 1'b1;
    for (int i = 0; i < n_rows; i++)
    begin
      row = tab[i];
      wait_accept();
      cmd_vld <= 1'b0;
      rng = xorshift32(rng);
      gap = rng % 21;
      repeat (gap) @(posedge clk);
      // Next command waits on cmd_vld while this one runs
      if (i + 1 < n_rows)
      begin
        cmd_in  <= tab[i + 1].cmd;
        cmd_vld <= 1'b1;
      end
      wait_frame(b);
      check_equal(b, row.hdr, "header byte");
      check_equal(cmd_rdy, 1'b0, "cmd_rdy during a command");
      @(posedge clk);
      if (i + 1 < n_rows)
      begin
        rng = xorshift32(rng);
        reply_mode <= tab[i + 1].mode;
        reply_bits <= 4'(1 + rng % 8);
      end
      if (row.cmd.wr.is_write)
      begin
        exp_frames += 2;
        wait_frame(b);
        check_equal(b, row.wdata, "write data byte");
        check_equal(cmd_rdy, 1'b0, "cmd_rdy before the data frame ends");
        @(negedge clk);
      end
      else
      begin
        exp_frames += 1;
        exp_reads  += 1;
        wait_read();
        check_equal(read_res.data, row.res.data, "read data");
        check_equal(read_res.err, row.res.err, "read error code");
        @(negedge clk);
        check_equal(read_vld, 1'b0, "read_vld pulse width");
      end
      check_equal(frames_seen, exp_frames, "frames seen by the device");
    end
    repeat (20 * uart_cfg_pkg::bit_cycles) @(posedge clk);
    @(negedge clk);
    check_equal(frames_seen, exp_frames, "frames seen by the device");
    check_equal(reads_seen, exp_reads, "read_vld pulses");
    check_equal(cmd_rdy, 1'b1, "cmd_rdy at the end");
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- uart_bridge_top.sv
`timescale 1ns/10ps

module uart_bridge_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  uart_cmd_pkg::cmd_word_u    cmd_in,
  input  logic                       cmd_vld,
  input  logic                       rx,
  output logic                       cmd_rdy,
  output logic                       tx,
  output logic                       read_vld,
  output uart_cmd_pkg::read_result_t read_res
);

  logic                    tx_vld;
  logic                    tx_rdy;
  logic                    tx_done;
  uart_cmd_pkg::tx_job_t   tx_job;
  logic                    rd_open;
  logic                    rd_close;
  logic                    rx_vld;
  uart_cmd_pkg::rx_frame_t rx_frame;

  cmd_decode u_cmd_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .tx_rdy   (tx_rdy),
    .tx_done  (tx_done),
    .rd_close (rd_close),
    .cmd_rdy  (cmd_rdy),
    .tx_vld   (tx_vld),
    .tx_job   (tx_job),
    .rd_open  (rd_open)
  );

  uart_tx_frame u_tx_frame (
    .clk     (clk),
    .rst_n   (rst_n),
    .tx_vld  (tx_vld),
    .tx_job  (tx_job),
    .tx_rdy  (tx_rdy),
    .tx_done (tx_done),
    .tx      (tx)
  );

  uart_rx_frame u_rx_frame (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_vld   (rx_vld),
    .rx_frame (rx_frame)
  );

  read_result u_read_result (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_open  (rd_open),
    .rx_vld   (rx_vld),
    .rx_frame (rx_frame),
    .rd_close (rd_close),
    .read_vld (read_vld),
    .read_res (read_res)
  );

endmodule

//--- uart_cfg_pkg.sv
package uart_cfg_pkg;

  // Line timing, 434 clocks per bit at 250 MHz
  localparam int bit_cycles      = 434;
  localparam int frame_bits      = 11;  // Start, 8 data, parity, stop
  localparam int gap_bits        = 16;  // Idle bit times between the two write frames
  localparam int rx_timeout_bits = 64;

  localparam int bit_cnt_w = $clog2(bit_cycles);
  localparam logic [bit_cnt_w-1:0] bit_last      = bit_cnt_w'(bit_cycles - 1);
  localparam logic [bit_cnt_w-1:0] half_bit_last = bit_cnt_w'(bit_cycles / 2 - 1);

  // Bit index inside a frame, the start bit is index 0
  localparam int frame_idx_w = $clog2(frame_bits);
  localparam logic [frame_idx_w-1:0] stop_idx = frame_idx_w'(frame_bits - 1);

  localparam int gap_cnt_w = $clog2(gap_bits);
  localparam logic [gap_cnt_w-1:0] gap_last = gap_cnt_w'(gap_bits - 1);

  // Reply window counted in clocks from the opening of a read
  localparam int timeout_cycles = rx_timeout_bits * bit_cycles;
  localparam int timeout_cnt_w  = $clog2(timeout_cycles);
  localparam logic [timeout_cnt_w-1:0] timeout_last = timeout_cnt_w'(timeout_cycles - 1);

endpackage

//--- uart_cmd_pkg.sv
package uart_cmd_pkg;

  typedef struct packed {
    logic       is_write;
    logic [6:0] addr;
    logic [7:0] data;
  } cmd_wr_t;

  typedef struct packed {
    logic       is_write;
    logic [6:0] addr;
    logic [7:0] rsvd;  // Ignored on a read
  } cmd_rd_t;

  // Host command word, bit 15 selects the view
  typedef union packed {
    cmd_wr_t wr;
    cmd_rd_t rd;
  } cmd_word_u;

  // One frame payload for the tx engine, sent data first and LSB first
  typedef struct packed {
    logic [7:0] data;
    logic       parity;
    logic       stop;
  } tx_job_t;

  typedef struct packed {
    logic [7:0] data;
    logic       parity_ok;
    logic       stop_ok;
  } rx_frame_t;

  typedef enum logic [1:0] {
    err_none,
    err_parity,
    err_stop,
    err_timeout
  } read_err_e;

  typedef struct packed {
    logic [7:0] data;
    read_err_e  err;
  } read_result_t;

endpackage

//--- uart_device_model.sv
`timescale 1ns/10ps

module uart_device_model (
  input  logic       clk,
  input  logic       tx,
  input  logic [1:0] reply_mode,  // 0 normal, 1 bad parity, 2 bad stop, 3 silent
  input  logic [3:0] reply_bits,  // Reply delay in bit times
  output logic       rx,
  output logic       frame_vld,
  output logic [7:0] frame_byte,
  output logic       fmt_err
);

  localparam int bit_len = uart_cfg_pkg::bit_cycles;

  logic [7:0] mem [128];

  // Receives one frame from the bridge, hi counts the idle clocks before its start bit
  task automatic get_frame(output logic [7:0] b, output int hi);
    logic [10:0] f;
    hi = 0;
    @(posedge clk);
    while (tx !== 1'b0)
    begin
      @(posedge clk);
      hi++;
    end
    repeat (bit_len / 2 - 1) @(posedge clk);  // Middle of the start bit
    f[0] = tx;
    for (int i = 1; i < uart_cfg_pkg::frame_bits; i++)
    begin
      repeat (bit_len) @(posedge clk);
      f[i] = tx;
    end
    if (f[10] !== 1'b1)
    begin
      $display("Device model: frame at %0t ns has no stop bit", $time);
      fmt_err = 1'b1;
    end
    if (^f[9:1] !== 1'b0)
    begin
      $display("Device model: frame at %0t ns has wrong parity", $time);
      fmt_err = 1'b1;
    end
    b = f[8:1];
    frame_byte <= b;
    frame_vld  <= 1'b1;
    @(posedge clk);
    frame_vld <= 1'b0;
  endtask

  task automatic send_reply(input logic [7:0] d, input logic [1:0] mode, input logic [3:0] dly);
    logic [10:0] f;
    f = {mode != 2'd2, (^d) ^ (mode == 2'd1), d, 1'b0};  // Stop, parity, data, start
    repeat (int'(dly) * bit_len) @(posedge clk);
    for (int i = 0; i < uart_cfg_pkg::frame_bits; i++)
    begin
      rx <= f[i];
      repeat (bit_len) @(posedge clk);
    end
    rx <= 1'b1;
  endtask

  initial
  begin
    logic [7:0] hdr;
    logic [7:0] d;
    int         hi;
    logic [1:0] mode;
    logic [3:0] dly;
    rx         = 1'b1;
    frame_vld  = 1'b0;
    frame_byte = '0;
    fmt_err    = 1'b0;
    for (int a = 0; a < 128; a++)
      mem[a] = 8'(a) ^ 8'h5A;
    forever
    begin
      get_frame(hdr, hi);
      if (hdr[7])
      begin
        get_frame(d, hi);
        // Idle time counted from mid stop bit of the header
        if (hi < uart_cfg_pkg::gap_bits * bit_len)
        begin
          $display("Device model: write gap of %0d clocks is shorter than %0d bit times",
                   hi, uart_cfg_pkg::gap_bits);
          fmt_err = 1'b1;
        end
        mem[hdr[6:0]] = d;
      end
      else
      begin
        mode = reply_mode;  // Latched when the read header arrives
        dly  = reply_bits;
        if (mode != 2'd3)
          send_reply(mem[hdr[6:0]], mode, dly);
      end
    end
  end

endmodule

//--- uart_rx_frame.sv
`timescale 1ns/10ps

module uart_rx_frame (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    rx,
  output logic                    rx_vld,
  output uart_cmd_pkg::rx_frame_t rx_frame
);

  typedef enum logic [1:0] {
    s_idle,
    s_start,
    s_bits
  } state_e;

  state_e                               state;
  logic [1:0]                           rx_sync;
  logic                                 rx_prev;
  logic                                 rx_s;
  logic                                 fall;
  logic [uart_cfg_pkg::bit_cnt_w-1:0]   bit_cnt;
  logic [uart_cfg_pkg::frame_idx_w-1:0] bit_idx;
  logic [8:0]                           shreg;  // Parity on top, data below
  logic                                 sample;

  assign rx_s   = rx_sync[1];
  assign fall   = rx_prev && !rx_s;
  assign sample = (state == s_bits) && (bit_cnt == uart_cfg_pkg::bit_last);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_sync <= 2'b11;
      rx_prev <= 1'b1;
      state   <= s_idle;
      bit_cnt <= '0;
      bit_idx <= '0;
      rx_vld  <= 1'b0;
    end
    else
    begin
      rx_sync <= {rx_sync[0], rx};
      rx_prev <= rx_s;
      rx_vld  <= 1'b0;
      case (state)
        s_idle:
          if (fall)
          begin
            state   <= s_start;
            bit_cnt <= '0;
          end
        s_start:
          if (bit_cnt == uart_cfg_pkg::half_bit_last)
          begin
            bit_cnt <= '0;
            bit_idx <= 1'b1;
            // A glitch that is high again by mid-bit is no start bit
            state   <= rx_s ? s_idle : s_bits;
          end
          else
            bit_cnt <= bit_cnt + 1'b1;
        s_bits:
          if (sample)
          begin
            bit_cnt <= '0;
            if (bit_idx == uart_cfg_pkg::stop_idx)
            begin
              state  <= s_idle;
              rx_vld <= 1'b1;  // Mid stop bit
            end
            else
              bit_idx <= bit_idx + 1'b1;
          end
          else
            bit_cnt <= bit_cnt + 1'b1;
        default:
          state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if (bit_idx == uart_cfg_pkg::stop_idx)
      begin
        rx_frame.data      <= shreg[7:0];
        rx_frame.parity_ok <= ~^shreg;
        rx_frame.stop_ok   <= rx_s;
      end
      else
        shreg <= {rx_s, shreg[8:1]};  // LSB arrives first
    end
  end

endmodule

//--- uart_tx_frame.sv
`timescale 1ns/10ps

module uart_tx_frame (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  tx_vld,
  input  uart_cmd_pkg::tx_job_t tx_job,
  output logic                  tx_rdy,
  output logic                  tx_done,
  output logic                  tx
);

  logic                                 busy;
  logic [uart_cfg_pkg::bit_cnt_w-1:0]   bit_cnt;
  logic [uart_cfg_pkg::frame_idx_w-1:0] bit_idx;
  logic [9:0]                           shreg;  // Bits still to go after the start bit
  logic                                 bit_end;

  assign bit_end = busy && (bit_cnt == uart_cfg_pkg::bit_last);
  assign tx_rdy  = !busy;
  assign tx_done = bit_end && (bit_idx == uart_cfg_pkg::stop_idx);  // Last clock of the stop bit

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy    <= 1'b0;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end
    else if (!busy)
    begin
      if (tx_vld)
      begin
        busy    <= 1'b1;
        bit_cnt <= '0;
        bit_idx <= '0;
        tx      <= 1'b0;  // Start bit
      end
    end
    else if (bit_end)
    begin
      bit_cnt <= '0;
      if (bit_idx == uart_cfg_pkg::stop_idx)
      begin
        busy <= 1'b0;
        tx   <= 1'b1;
      end
      else
      begin
        bit_idx <= bit_idx + 1'b1;
        tx      <= shreg[0];
      end
    end
    else
      bit_cnt <= bit_cnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (!busy && tx_vld)
      shreg <= {tx_job.stop, tx_job.parity, tx_job.data};
    else if (bit_end)
      shreg <= {1'b1, shreg[9:1]};
  end

endmodule
